/* hw/pcpu_defs.svh */
`ifndef PCPU_DEFS_SVH
`define PCPU_DEFS_SVH

////////////////////////////////////////
// core widths
////////////////////////////////////////

`define PCPU_XLEN 32 // data and address width

`define PCPU_REG_CNT 32 // general registers, $0 included

////////////////////////////////////////
// fetch
////////////////////////////////////////

`define PCPU_RESET_PC 32'h0000_0000 // first fetch after reset

`endif

/* hw/pcpu_pkg.sv */
`include "pcpu_defs.svh"

package pcpu_pkg;

	////////////////////////////////////////
	// instruction encodings
	////////////////////////////////////////

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, // r-type, see funct
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDI    = 6'h08,
		OP_SLTI    = 6'h0a,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SRL = 6'h02,
		FN_ADD = 6'h20,
		FN_NOR = 6'h27,
		FN_SLT = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_NOR, ALU_SLT, ALU_SRL, ALU_LUI} alu_op_e;

	typedef enum logic [1:0] {FWD_REGFILE, FWD_FROM_MEM, FWD_FROM_WB} fwd_sel_e; // operand source

	typedef logic [$clog2(`PCPU_REG_CNT)-1:0] reg_addr_t;

	////////////////////////////////////////
	// pipeline registers
	////////////////////////////////////////

	typedef struct packed {
		logic [`PCPU_XLEN-1:0] pc_plus4;
		logic [`PCPU_XLEN-1:0] rs_val;
		logic [`PCPU_XLEN-1:0] rt_val;
		reg_addr_t             rs;
		reg_addr_t             rt;
		reg_addr_t             dst;      // rd or rt
		logic [`PCPU_XLEN-1:0] imm;      // already extended
		logic [4:0]            shamt;
		alu_op_e               alu_op;
		logic [`PCPU_XLEN-1:0] jump_target;
		logic                  reg_write;
		logic                  mem_read;
		logic                  mem_write;
		logic                  branch_eq;
		logic                  branch_ne;
		logic                  jump;
		logic                  use_imm;  // imm replaces rt as operand b
	} id_ex_t;

	typedef struct packed {
		logic [`PCPU_XLEN-1:0] result;     // alu out, also mem address
		logic [`PCPU_XLEN-1:0] store_data;
		reg_addr_t             dst;
		logic                  reg_write;
		logic                  mem_read;
		logic                  mem_write;
	} ex_mem_t;

	typedef struct packed {
		logic [`PCPU_XLEN-1:0] result;
		reg_addr_t             dst;
		logic                  reg_write;
		logic                  mem_read; // take mem_data_in instead of result
	} mem_wb_t;

endpackage

/* hw/pcpu_fetch.sv */
`timescale 1ns/100ps
`include "pcpu_defs.svh"

module pcpu_fetch (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall,
	input  logic                  flush,
	input  logic                  redirect,
	input  logic [`PCPU_XLEN-1:0] redirect_pc,
	input  logic [`PCPU_XLEN-1:0] inst_data,
	output logic [`PCPU_XLEN-1:0] inst_addr,
	output logic [`PCPU_XLEN-1:0] if_pc_plus4,
	output logic [`PCPU_XLEN-1:0] if_inst
);

	logic [`PCPU_XLEN-1:0] pc;
	logic [`PCPU_XLEN-1:0] pc_plus4;

	assign pc_plus4  = pc + `PCPU_XLEN'd4;
	assign inst_addr = pc; // imem answers in the same cycle

	// program counter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `PCPU_RESET_PC;
		end else if (redirect) begin // taken branch or j wins
			pc <= redirect_pc;
		end else if (!stall) begin
			pc <= pc_plus4;
		end
	end

	// fetch/decode register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_pc_plus4 <= '0;
			if_inst     <= '0; // zero word decodes as no-op
		end else if (flush) begin
			if_pc_plus4 <= '0;
			if_inst     <= '0; // drop the wrong-path fetch
		end else if (!stall) begin
			if_pc_plus4 <= pc_plus4;
			if_inst     <= inst_data;
		end
	end

endmodule

/* hw/pcpu_decode.sv */
`timescale 1ns/100ps
`include "pcpu_defs.svh"

module pcpu_decode (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall,
	input  logic                  flush,
	input  logic [`PCPU_XLEN-1:0] if_pc_plus4,
	input  logic [`PCPU_XLEN-1:0] if_inst,
	input  logic [`PCPU_XLEN-1:0] rs_val,
	input  logic [`PCPU_XLEN-1:0] rt_val,
	output pcpu_pkg::reg_addr_t   rs_addr,
	output pcpu_pkg::reg_addr_t   rt_addr,
	output pcpu_pkg::id_ex_t      id_ex
);

	pcpu_pkg::opcode_e     opcode;
	pcpu_pkg::funct_e      funct;
	pcpu_pkg::reg_addr_t   rd_addr;
	logic [15:0]           imm16;
	logic [`PCPU_XLEN-1:0] imm_sext;
	pcpu_pkg::id_ex_t      dec;

	////////////////////////////////////////
	// field split
	////////////////////////////////////////

	assign opcode   = pcpu_pkg::opcode_e'(if_inst[31:26]);
	assign funct    = pcpu_pkg::funct_e'(if_inst[5:0]);
	assign rs_addr  = if_inst[25:21];
	assign rt_addr  = if_inst[20:16];
	assign rd_addr  = if_inst[15:11];
	assign imm16    = if_inst[15:0];
	assign imm_sext = {{(`PCPU_XLEN-16){imm16[15]}}, imm16};

	always_comb begin
		dec             = '0; // unknown encodings leave every flag clear
		dec.pc_plus4    = if_pc_plus4;
		dec.rs_val      = rs_val;
		dec.rt_val      = rt_val;
		dec.rs          = rs_addr;
		dec.rt          = rt_addr;
		dec.dst         = rt_addr; // immediate forms
		dec.imm         = imm_sext;
		dec.shamt       = if_inst[10:6];
		dec.jump_target = {if_pc_plus4[`PCPU_XLEN-1 -: 4], if_inst[25:0], 2'b00};
		case (opcode)
			pcpu_pkg::OP_SPECIAL: begin
				dec.dst = rd_addr;
				case (funct)
					pcpu_pkg::FN_ADD: begin
						dec.alu_op    = pcpu_pkg::ALU_ADD;
						dec.reg_write = 1'b1;
					end
					pcpu_pkg::FN_NOR: begin
						dec.alu_op    = pcpu_pkg::ALU_NOR;
						dec.reg_write = 1'b1;
					end
					pcpu_pkg::FN_SLT: begin
						dec.alu_op    = pcpu_pkg::ALU_SLT;
						dec.reg_write = 1'b1;
					end
					pcpu_pkg::FN_SRL: begin
						dec.alu_op    = pcpu_pkg::ALU_SRL; // shifts rt
						dec.reg_write = 1'b1;
					end
					default: ; // sll $0 and friends, no-op
				endcase
			end
			pcpu_pkg::OP_ADDI: begin
				dec.alu_op    = pcpu_pkg::ALU_ADD;
				dec.use_imm   = 1'b1;
				dec.reg_write = 1'b1;
			end
			pcpu_pkg::OP_SLTI: begin
				dec.alu_op    = pcpu_pkg::ALU_SLT;
				dec.use_imm   = 1'b1;
				dec.reg_write = 1'b1;
			end
			pcpu_pkg::OP_LUI: begin
				dec.imm       = {imm16, {(`PCPU_XLEN-16){1'b0}}}; // upper half
				dec.alu_op    = pcpu_pkg::ALU_LUI;
				dec.use_imm   = 1'b1;
				dec.reg_write = 1'b1;
			end
			pcpu_pkg::OP_LW: begin
				dec.alu_op    = pcpu_pkg::ALU_ADD; // base + offset
				dec.use_imm   = 1'b1;
				dec.reg_write = 1'b1;
				dec.mem_read  = 1'b1;
			end
			pcpu_pkg::OP_SW: begin
				dec.alu_op    = pcpu_pkg::ALU_ADD;
				dec.use_imm   = 1'b1;
				dec.mem_write = 1'b1;
			end
			pcpu_pkg::OP_BEQ: begin
				dec.alu_op    = pcpu_pkg::ALU_SUB; // zero on equal
				dec.branch_eq = 1'b1;
			end
			pcpu_pkg::OP_BNE: begin
				dec.alu_op    = pcpu_pkg::ALU_SUB;
				dec.branch_ne = 1'b1;
			end
			pcpu_pkg::OP_J: dec.jump = 1'b1;
			default: ;
		endcase
	end

	// decode/execute register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else if (stall || flush) begin
			id_ex <= '0; // bubble
		end else begin
			id_ex <= dec;
		end
	end

endmodule

/* hw/pcpu_regfile.sv */
`timescale 1ns/100ps
`include "pcpu_defs.svh"

module pcpu_regfile (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [$clog2(`PCPU_REG_CNT)-1:0] rs_addr,
	input  logic [$clog2(`PCPU_REG_CNT)-1:0] rt_addr,
	input  pcpu_pkg::mem_wb_t                 wb,
	input  logic [`PCPU_XLEN-1:0]             wb_value,
	output logic [`PCPU_XLEN-1:0]             rs_val,
	output logic [`PCPU_XLEN-1:0]             rt_val
);

	logic [`PCPU_XLEN-1:0] regs [`PCPU_REG_CNT];
	logic                  wr_en;

	assign wr_en = wb.reg_write && (wb.dst != '0); // $0 never written

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `PCPU_REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.dst] <= wb_value;
		end
	end

	// reads see this cycle's write
	assign rs_val = (rs_addr == '0)                ? '0       :
	                (wr_en && (wb.dst == rs_addr)) ? wb_value : regs[rs_addr];
	assign rt_val = (rt_addr == '0)                ? '0       :
	                (wr_en && (wb.dst == rt_addr)) ? wb_value : regs[rt_addr];

endmodule

/* hw/pcpu_execute.sv */
`timescale 1ns/100ps
`include "pcpu_defs.svh"

module pcpu_execute (
	input  logic                  clk,
	input  logic                  rst_n,
	input  pcpu_pkg::id_ex_t      id_ex,
	input  pcpu_pkg::fwd_sel_e    fwd_a,
	input  pcpu_pkg::fwd_sel_e    fwd_b,
	input  logic [`PCPU_XLEN-1:0] mem_data_in,
	output pcpu_pkg::ex_mem_t     ex_mem,
	output pcpu_pkg::mem_wb_t     mem_wb,
	output logic [`PCPU_XLEN-1:0] wb_value,
	output logic                  redirect,
	output logic [`PCPU_XLEN-1:0] redirect_pc
);

	logic [`PCPU_XLEN-1:0] op_a;
	logic [`PCPU_XLEN-1:0] rt_fwd; // forwarded rt, also store data
	logic [`PCPU_XLEN-1:0] op_b;
	logic [`PCPU_XLEN-1:0] alu_y;
	logic [`PCPU_XLEN-1:0] branch_tgt;
	logic                  alu_zero;

	function automatic logic [`PCPU_XLEN-1:0] fwd_pick(
		input pcpu_pkg::fwd_sel_e    sel,
		input logic [`PCPU_XLEN-1:0] reg_val,
		input logic [`PCPU_XLEN-1:0] mem_val,
		input logic [`PCPU_XLEN-1:0] wb_val
	);
		case (sel)
			pcpu_pkg::FWD_FROM_MEM: return mem_val;
			pcpu_pkg::FWD_FROM_WB:  return wb_val;
			default:                return reg_val;
		endcase
	endfunction

	////////////////////////////////////////
	// operands and alu
	////////////////////////////////////////

	assign op_a   = fwd_pick(fwd_a, id_ex.rs_val, ex_mem.result, wb_value);
	assign rt_fwd = fwd_pick(fwd_b, id_ex.rt_val, ex_mem.result, wb_value);
	assign op_b   = id_ex.use_imm ? id_ex.imm : rt_fwd;

	always_comb begin
		case (id_ex.alu_op)
			pcpu_pkg::ALU_SUB: alu_y = op_a - op_b;
			pcpu_pkg::ALU_NOR: alu_y = ~(op_a | op_b);
			pcpu_pkg::ALU_SLT: alu_y = {{(`PCPU_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			pcpu_pkg::ALU_SRL: alu_y = op_b >> id_ex.shamt; // rt operand
			pcpu_pkg::ALU_LUI: alu_y = op_b; // imm already high
			default:           alu_y = op_a + op_b;
		endcase
	end

	////////////////////////////////////////
	// branch resolution
	////////////////////////////////////////

	assign alu_zero    = (alu_y == '0);
	assign branch_tgt  = id_ex.pc_plus4 + (id_ex.imm << 2);
	assign redirect    = id_ex.jump || (id_ex.branch_eq && alu_zero) ||
	                     (id_ex.branch_ne && !alu_zero);
	assign redirect_pc = id_ex.jump ? id_ex.jump_target : branch_tgt;

	// execute/memory and memory/write-back registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
			mem_wb <= '0;
		end else begin
			ex_mem.result     <= alu_y;
			ex_mem.store_data <= rt_fwd;
			ex_mem.dst        <= id_ex.dst;
			ex_mem.reg_write  <= id_ex.reg_write;
			ex_mem.mem_read   <= id_ex.mem_read;
			ex_mem.mem_write  <= id_ex.mem_write;
			mem_wb.result     <= ex_mem.result;
			mem_wb.dst        <= ex_mem.dst;
			mem_wb.reg_write  <= ex_mem.reg_write;
			mem_wb.mem_read   <= ex_mem.mem_read;
		end
	end

	assign wb_value = mem_wb.mem_read ? mem_data_in : mem_wb.result; // load data lands now

endmodule

/* hw/pcpu_hazard.sv */
`timescale 1ns/100ps
`include "pcpu_defs.svh"

module pcpu_hazard (
	input  logic [$clog2(`PCPU_REG_CNT)-1:0] rs_addr,
	input  logic [$clog2(`PCPU_REG_CNT)-1:0] rt_addr,
	input  pcpu_pkg::id_ex_t                  id_ex,
	input  pcpu_pkg::ex_mem_t                 ex_mem,
	input  pcpu_pkg::mem_wb_t                 mem_wb,
	input  logic                              redirect,
	output logic                              stall,
	output logic                              flush,
	output pcpu_pkg::fwd_sel_e                fwd_a,
	output pcpu_pkg::fwd_sel_e                fwd_b
);

	logic load_in_ex;

	// youngest producer first
	function automatic pcpu_pkg::fwd_sel_e fwd_pick(
		input pcpu_pkg::reg_addr_t src,
		input pcpu_pkg::ex_mem_t   mem,
		input pcpu_pkg::mem_wb_t   wb
	);
		if (src == '0) return pcpu_pkg::FWD_REGFILE; // $0 stays zero
		if (mem.reg_write && (mem.dst == src)) return pcpu_pkg::FWD_FROM_MEM;
		if (wb.reg_write && (wb.dst == src)) return pcpu_pkg::FWD_FROM_WB;
		return pcpu_pkg::FWD_REGFILE;
	endfunction

	assign fwd_a = fwd_pick(id_ex.rs, ex_mem, mem_wb);
	assign fwd_b = fwd_pick(id_ex.rt, ex_mem, mem_wb);

	// load data arrives a cycle too late for the next instruction
	assign load_in_ex = id_ex.mem_read && (id_ex.dst != '0);
	assign stall      = load_in_ex && ((id_ex.dst == rs_addr) || (id_ex.dst == rt_addr));
	assign flush      = redirect; // kill decode and fetch

endmodule

/* hw/pcpu_top.sv */
`timescale 1ns/100ps
`include "pcpu_defs.svh"

module pcpu_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`PCPU_XLEN-1:0] inst_data,
	input  logic [`PCPU_XLEN-1:0] mem_data_in,
	output logic [`PCPU_XLEN-1:0] inst_addr,
	output logic [`PCPU_XLEN-1:0] mem_addr,
	output logic [`PCPU_XLEN-1:0] mem_data,
	output logic                  mem_we
);

	logic [`PCPU_XLEN-1:0] if_pc_plus4;
	logic [`PCPU_XLEN-1:0] if_inst;
	pcpu_pkg::reg_addr_t   rs_addr;
	pcpu_pkg::reg_addr_t   rt_addr;
	logic [`PCPU_XLEN-1:0] rs_val;
	logic [`PCPU_XLEN-1:0] rt_val;
	pcpu_pkg::id_ex_t      id_ex;
	pcpu_pkg::ex_mem_t     ex_mem;
	pcpu_pkg::mem_wb_t     mem_wb;
	logic [`PCPU_XLEN-1:0] wb_value;
	pcpu_pkg::fwd_sel_e    fwd_a;
	pcpu_pkg::fwd_sel_e    fwd_b;
	logic                  redirect;
	logic [`PCPU_XLEN-1:0] redirect_pc;
	logic                  stall;
	logic                  flush;

	pcpu_fetch fetch_inst (
		.clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
		.redirect(redirect), .redirect_pc(redirect_pc), .inst_data(inst_data),
		.inst_addr(inst_addr), .if_pc_plus4(if_pc_plus4), .if_inst(if_inst)
	);

	pcpu_decode decode_inst (
		.clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
		.if_pc_plus4(if_pc_plus4), .if_inst(if_inst), .rs_val(rs_val), .rt_val(rt_val),
		.rs_addr(rs_addr), .rt_addr(rt_addr), .id_ex(id_ex)
	);

	pcpu_regfile regfile_inst (
		.clk(clk), .rst_n(rst_n), .rs_addr(rs_addr), .rt_addr(rt_addr),
		.wb(mem_wb), .wb_value(wb_value), .rs_val(rs_val), .rt_val(rt_val)
	);

	pcpu_execute execute_inst (
		.clk(clk), .rst_n(rst_n), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.mem_data_in(mem_data_in), .ex_mem(ex_mem), .mem_wb(mem_wb), .wb_value(wb_value),
		.redirect(redirect), .redirect_pc(redirect_pc)
	);

	pcpu_hazard hazard_inst (
		.rs_addr(rs_addr), .rt_addr(rt_addr), .id_ex(id_ex), .ex_mem(ex_mem),
		.mem_wb(mem_wb), .redirect(redirect), .stall(stall), .flush(flush),
		.fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	// data memory port, straight off the execute/memory register
	assign mem_addr = ex_mem.result;
	assign mem_data = ex_mem.store_data;
	assign mem_we   = ex_mem.mem_write;

endmodule

/* bench/pcpu_asserts.sv */
`timescale 1ns/100ps
`include "pcpu_defs.svh"

module pcpu_asserts (
	input logic                  clk,
	input logic                  rst_n,
	input logic [`PCPU_XLEN-1:0] inst_addr,
	input logic                  mem_we,
	input logic                  stall,
	input logic                  redirect
);

	// no store may leak out while the core is held in reset
	a_we_in_reset: assert property (@(posedge clk) !rst_n |-> !mem_we)
		else $error("mem_we high while rst_n low");

	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		inst_addr[1:0] == 2'b00) // word fetches only
		else $error("inst_addr 0x%h not word aligned", inst_addr);

	a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
		(stall && !redirect) |=> $stable(inst_addr)) // redirect outranks stall
		else $error("inst_addr moved during a load-use stall");

endmodule

bind pcpu_top pcpu_asserts pcpu_asserts_inst (
	.clk(clk), .rst_n(rst_n), .inst_addr(inst_addr), .mem_we(mem_we),
	.stall(stall), .redirect(redirect)
);

/* bench/pcpu_tb.sv */
`timescale 1ns/100ps
`include "pcpu_defs.svh"

module pcpu_tb;

	localparam int CLK_PERIOD    = 40;
	localparam int RESET_CYCLES  = 10;
	localparam int SETTLE_CYCLES = 8; // quiet time to catch stray stores
	localparam int LEN_RESET = 6;
	localparam int LEN_ALU   = 41;
	localparam int LEN_FWD   = 13;
	localparam int LEN_LOAD  = 4;
	localparam int LEN_BR    = 26;
	localparam int WATCHDOG_CYCLES = 10 * (LEN_RESET + LEN_ALU + LEN_FWD + LEN_LOAD + LEN_BR)
	                                 + 5 * (RESET_CYCLES + SETTLE_CYCLES + 4);

	logic                  clk = 1'b0;
	logic                  rst_n = 1'b0;
	logic [`PCPU_XLEN-1:0] inst_data;
	logic [`PCPU_XLEN-1:0] mem_data_in = '0;
	logic [`PCPU_XLEN-1:0] inst_addr;
	logic [`PCPU_XLEN-1:0] mem_addr;
	logic [`PCPU_XLEN-1:0] mem_data;
	logic                  mem_we;

	logic [31:0]           imem [256];
	logic [`PCPU_XLEN-1:0] dmem [256];
	logic [`PCPU_XLEN-1:0] store_addr_q[$]; // what the DUT wrote
	logic [`PCPU_XLEN-1:0] store_data_q[$];
	logic [`PCPU_XLEN-1:0] exp_addr_q[$];   // what it should have written
	logic [`PCPU_XLEN-1:0] exp_data_q[$];
	logic [31:0]           lcg_state = 32'd16865;
	int                    prog_idx;
	int                    n_checks;
	int                    value_errs;
	int                    other_errs;

	pcpu_top pcpu_top_inst (
		.clk(clk), .rst_n(rst_n), .inst_data(inst_data), .mem_data_in(mem_data_in),
		.inst_addr(inst_addr), .mem_addr(mem_addr), .mem_data(mem_data), .mem_we(mem_we)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////
	// memory models
	////////////////////////////////////////

	assign inst_data = imem[inst_addr[9:2]]; // async imem

	always @(posedge clk) begin
		mem_data_in <= dmem[mem_addr[9:2]]; // sync read, valid next cycle
		if (mem_we === 1'b1) begin
			dmem[mem_addr[9:2]] <= mem_data;
			store_addr_q.push_back(mem_addr);
			store_data_q.push_back(mem_data);
		end
	end

	////////////////////////////////////////
	// encoding and reference helpers
	////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [15:0] rand16();
		logic [31:0] r;
		r = lcg_next();
		return r[31:16]; // upper bits, better spread
	endfunction

	function automatic logic [31:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic logic [31:0] r_type(input pcpu_pkg::funct_e fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {pcpu_pkg::OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] i_type(input pcpu_pkg::opcode_e op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] j_type(input int idx);
		logic [25:0] target;
		target = idx[25:0]; // word index, upper pc bits are zero here
		return {pcpu_pkg::OP_J, target};
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[prog_idx] = w;
		prog_idx++;
	endtask

	task automatic emit_nops(input int n);
		prog_idx += n; // imem already cleared to zero words
	endtask

	task automatic emit_spaced(input logic [31:0] w);
		emit(w);
		emit_nops(3); // result lands in the regfile before any reader
	endtask

	task automatic expect_store(input logic [`PCPU_XLEN-1:0] addr, input logic [`PCPU_XLEN-1:0] data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic check_store(input int idx, input logic [`PCPU_XLEN-1:0] exp_addr,
		input logic [`PCPU_XLEN-1:0] exp_data, input logic [`PCPU_XLEN-1:0] act_addr,
		input logic [`PCPU_XLEN-1:0] act_data);
		n_checks++;
		if (act_addr !== exp_addr || act_data !== exp_data) begin
			value_errs++;
			$display("ERROR %0t: store[%0d] mem_addr expected %h got %h, mem_data expected %h got %h",
				$time, idx, exp_addr, act_addr, exp_data, act_data);
		end
	endtask

	task automatic check_word(input string name, input logic [`PCPU_XLEN-1:0] exp,
		input logic [`PCPU_XLEN-1:0] act);
		n_checks++;
		if (act !== exp) begin
			value_errs++;
			$display("ERROR %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			value_errs++;
			$display("ERROR %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic note_failure(input string msg);
		other_errs++;
		$display("FAILURE %0t: %s", $time, msg);
	endtask

	////////////////////////////////////////
	// reset and run control
	////////////////////////////////////////

	task automatic start_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;                         // all no-ops
			dmem[i] = 32'h5a00_0000 ^ (i << 2); // address-dependent fill
		end
		prog_idx = 0;
	endtask

	task automatic release_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		store_addr_q.delete(); // old program is long dead by now
		store_data_q.delete();
		rst_n <= 1'b1;
	endtask

	task automatic run_program(input int len);
		int i;
		int n;
		i = 0;
		while (store_addr_q.size() < exp_addr_q.size() && i < len * 10) begin
			@(negedge clk);
			i++;
		end
		repeat (SETTLE_CYCLES) @(negedge clk);
		if (store_addr_q.size() != exp_addr_q.size())
			note_failure($sformatf("store log holds %0d entries where %0d were expected",
				store_addr_q.size(), exp_addr_q.size()));
		n = (store_addr_q.size() < exp_addr_q.size()) ? store_addr_q.size() : exp_addr_q.size();
		for (i = 0; i < n; i++)
			check_store(i, exp_addr_q[i], exp_data_q[i], store_addr_q[i], store_data_q[i]);
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic reset_state();
		int i;
		start_reset();
		emit_nops(4);
		emit(i_type(pcpu_pkg::OP_SW, 5'd0, 5'd0, 16'h0040)); // fetched at 0x10
		emit(j_type(prog_idx));                              // park
		expect_store(32'h40, 32'h0);
		release_reset();
		@(negedge clk);
		check_word("inst_addr", `PCPU_RESET_PC, inst_addr);
		for (i = 0; i < 16 && inst_addr !== 32'h10; i++) begin
			check_bit("mem_we", 1'b0, mem_we); // quiet until the store
			@(negedge clk);
		end
		if (inst_addr !== 32'h10)
			note_failure("fetch never reached the store at 0x10");
		for (i = 1; i <= 3; i++) begin
			@(negedge clk);
			check_bit("mem_we", i == 3, mem_we); // rises three cycles after fetch
		end
		run_program(LEN_RESET);
	endtask

	task automatic alu_ops();
		logic [15:0] ia;
		logic [15:0] ib;
		logic [15:0] ic;
		logic [15:0] id;
		logic [4:0]  sh;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] v [1:8];
		ia = rand16();
		ib = rand16();
		ic = rand16();
		id = rand16();
		sh = rand16();
		a = sext16(ia);
		b = sext16(ib);
		v[1] = a;
		v[2] = b;
		v[3] = ~(a | b);
		v[4] = a + b;
		v[5] = v[3] >> sh;                            // logical, zero fill
		v[6] = {31'b0, $signed(a) < $signed(b)};
		v[7] = {31'b0, $signed(b) < $signed(sext16(ic))};
		v[8] = {id, 16'h0};
		start_reset();
		emit_spaced(i_type(pcpu_pkg::OP_ADDI, 5'd0, 5'd1, ia));
		emit_spaced(i_type(pcpu_pkg::OP_ADDI, 5'd0, 5'd2, ib));
		emit_spaced(r_type(pcpu_pkg::FN_NOR, 5'd1, 5'd2, 5'd3, 5'd0));
		emit_spaced(r_type(pcpu_pkg::FN_ADD, 5'd1, 5'd2, 5'd4, 5'd0));
		emit_spaced(r_type(pcpu_pkg::FN_SRL, 5'd0, 5'd3, 5'd5, sh));
		emit_spaced(r_type(pcpu_pkg::FN_SLT, 5'd1, 5'd2, 5'd6, 5'd0));
		emit_spaced(i_type(pcpu_pkg::OP_SLTI, 5'd2, 5'd7, ic));
		emit_spaced(i_type(pcpu_pkg::OP_LUI, 5'd0, 5'd8, id));
		for (int k = 1; k <= 8; k++) begin
			emit(i_type(pcpu_pkg::OP_SW, 5'd0, k[4:0], 16'h0100 + 16'(4 * (k - 1))));
			expect_store(32'h100 + 4 * (k - 1), v[k]);
		end
		emit(j_type(prog_idx));
		release_reset();
		run_program(LEN_ALU);
	endtask

	task automatic forwarding_chain();
		logic [15:0] k0;
		logic [15:0] k1;
		logic [15:0] k2;
		logic [31:0] r1;
		logic [31:0] r3;
		logic [31:0] r4;
		k0 = rand16();
		k1 = rand16();
		k2 = rand16();
		r1 = ~sext16(k0);
		r3 = r1 + sext16(k1);
		r4 = r3 + r1;
		start_reset();
		emit_spaced(i_type(pcpu_pkg::OP_ADDI, 5'd0, 5'd2, k0));
		emit(r_type(pcpu_pkg::FN_NOR, 5'd2, 5'd0, 5'd1, 5'd0)); // no spacing from here
		emit(i_type(pcpu_pkg::OP_ADDI, 5'd1, 5'd3, k1));
		emit(r_type(pcpu_pkg::FN_ADD, 5'd3, 5'd1, 5'd4, 5'd0)); // mem and wb sources
		emit(i_type(pcpu_pkg::OP_ADDI, 5'd4, 5'd5, k2));
		emit(i_type(pcpu_pkg::OP_SW, 5'd0, 5'd5, 16'h0200));    // store data forwarded
		emit(i_type(pcpu_pkg::OP_SW, 5'd0, 5'd4, 16'h0204));
		emit(i_type(pcpu_pkg::OP_SW, 5'd0, 5'd3, 16'h0208));
		emit(i_type(pcpu_pkg::OP_SW, 5'd0, 5'd1, 16'h020c));
		emit(j_type(prog_idx));
		expect_store(32'h200, r4 + sext16(k2));
		expect_store(32'h204, r4);
		expect_store(32'h208, r3);
		expect_store(32'h20c, r1);
		release_reset();
		run_program(LEN_FWD);
	endtask

	task automatic load_use_stall();
		logic [31:0] w;
		w = lcg_next();
		start_reset();
		dmem[32'h80 >> 2] = w;
		emit(i_type(pcpu_pkg::OP_LW, 5'd0, 5'd1, 16'h0080));
		emit(i_type(pcpu_pkg::OP_ADDI, 5'd1, 5'd2, 16'h0001)); // needs the load, stalls
		emit(i_type(pcpu_pkg::OP_SW, 5'd0, 5'd2, 16'h0084));
		emit(j_type(prog_idx));
		expect_store(32'h84, w + 32'd1);
		release_reset();
		run_program(LEN_LOAD);
	endtask

	task automatic branch_paths();
		logic [15:0] ra;
		logic [15:0] rb;
		ra = rand16();
		rb = ra ^ 16'h0001; // never equal to ra
		start_reset();
		emit_spaced(i_type(pcpu_pkg::OP_ADDI, 5'd0, 5'd1, ra));
		emit_spaced(i_type(pcpu_pkg::OP_ADDI, 5'd0, 5'd2, ra));
		emit_spaced(i_type(pcpu_pkg::OP_ADDI, 5'd0, 5'd3, rb));
		emit(i_type(pcpu_pkg::OP_BEQ, 5'd1, 5'd2, 16'd1)); // taken
		emit(i_type(pcpu_pkg::OP_SW, 5'd0, 5'd2, 16'h0300));
		emit(i_type(pcpu_pkg::OP_SW, 5'd0, 5'd1, 16'h0304));
		emit(i_type(pcpu_pkg::OP_BEQ, 5'd1, 5'd3, 16'd1)); // falls through
		emit(i_type(pcpu_pkg::OP_SW, 5'd0, 5'd3, 16'h0308));
		emit(i_type(pcpu_pkg::OP_BNE, 5'd1, 5'd3, 16'd1)); // taken
		emit(i_type(pcpu_pkg::OP_SW, 5'd0, 5'd2, 16'h030c));
		emit(i_type(pcpu_pkg::OP_SW, 5'd0, 5'd1, 16'h0310));
		emit(i_type(pcpu_pkg::OP_BNE, 5'd1, 5'd2, 16'd1)); // falls through
		emit(i_type(pcpu_pkg::OP_SW, 5'd0, 5'd3, 16'h0314));
		emit(j_type(prog_idx + 2));                         // hop one store
		emit(i_type(pcpu_pkg::OP_SW, 5'd0, 5'd2, 16'h0318));
		emit(i_type(pcpu_pkg::OP_SW, 5'd0, 5'd1, 16'h031c));
		emit(j_type(prog_idx));
		expect_store(32'h304, sext16(ra));
		expect_store(32'h308, sext16(rb));
		expect_store(32'h310, sext16(ra));
		expect_store(32'h314, sext16(rb));
		expect_store(32'h31c, sext16(ra));
		release_reset();
		run_program(LEN_BR);
	endtask

	////////////////////////////////////////
	// sequence and watchdog
	////////////////////////////////////////

	initial begin
		n_checks = 0;
		value_errs = 0;
		other_errs = 0;
		reset_state();
		alu_ops();
		forwarding_chain();
		load_use_stall();
		branch_paths();
		$display("checks %0d, value errors %0d, other errors %0d", n_checks, value_errs,
			other_errs);
		if (value_errs + other_errs == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: the run hung and was stopped after %0d cycles", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

/* list.f */
+incdir+hw
hw/pcpu_pkg.sv
hw/pcpu_fetch.sv
hw/pcpu_decode.sv
hw/pcpu_regfile.sv
hw/pcpu_execute.sv
hw/pcpu_hazard.sv
hw/pcpu_top.sv
bench/pcpu_asserts.sv
bench/pcpu_tb.sv

/* Bender.yml */
package:
  name: pcpu

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/pcpu_pkg.sv
      - hw/pcpu_fetch.sv
      - hw/pcpu_decode.sv
      - hw/pcpu_regfile.sv
      - hw/pcpu_execute.sv
      - hw/pcpu_hazard.sv
      - hw/pcpu_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - bench/pcpu_asserts.sv
      - bench/pcpu_tb.sv
